/* design/attn_pkg.sv */
package attn_pkg;

    // Matrix geometry
    localparam int dim = 8;
    localparam int mat_size = dim * dim;

    // Scores are divided by this before the ReLU result is stored
    localparam int score_divisor = 3;

    typedef logic signed [7:0]  elem_t;
    typedef logic signed [19:0] proj_t;
    typedef logic signed [40:0] score_t;
    typedef logic signed [63:0] acc_t;

    typedef logic [$clog2(dim)-1:0] idx_t;

    // Row count T is 1, 4 or 8
    typedef logic [3:0] t_sel_t;

    // One element of each matrix per load beat
    typedef struct packed {
        elem_t in_data;
        elem_t w_q;
        elem_t w_k;
        elem_t w_v;
    } load_beat_t;

    typedef enum logic [2:0] {
        ph_idle   = 3'd0,
        ph_load   = 3'd1,
        ph_proj_q = 3'd2,
        ph_proj_k = 3'd3,
        ph_proj_v = 3'd4,
        ph_score  = 3'd5,
        ph_drain  = 3'd6,
        ph_emit   = 3'd7
    } phase_e;

endpackage

/* design/attn_ctrl_fsm.sv */
`timescale 1ns/1ps

module attn_ctrl_fsm (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  attn_pkg::t_sel_t t_rows,
    input  logic             phase_done,
    output attn_pkg::phase_e phase,
    output attn_pkg::t_sel_t t_lat
);

    attn_pkg::phase_e phase_nxt;

    always_comb begin
        phase_nxt = phase;
        case (phase)
            attn_pkg::ph_idle: begin
                if (in_valid) begin
                    phase_nxt = attn_pkg::ph_load;
                end
            end
            attn_pkg::ph_load: begin
                if (phase_done) begin
                    phase_nxt = attn_pkg::ph_proj_q;
                end
            end
            attn_pkg::ph_proj_q: begin
                if (phase_done) begin
                    phase_nxt = attn_pkg::ph_proj_k;
                end
            end
            attn_pkg::ph_proj_k: begin
                if (phase_done) begin
                    phase_nxt = attn_pkg::ph_proj_v;
                end
            end
            attn_pkg::ph_proj_v: begin
                if (phase_done) begin
                    phase_nxt = attn_pkg::ph_score;
                end
            end
            attn_pkg::ph_score: begin
                if (phase_done) begin
                    phase_nxt = attn_pkg::ph_drain;
                end
            end
            // One spare cycle for the last score write
            attn_pkg::ph_drain: begin
                phase_nxt = attn_pkg::ph_emit;
            end
            attn_pkg::ph_emit: begin
                if (phase_done) begin
                    phase_nxt = attn_pkg::ph_idle;
                end
            end
            default: begin
                phase_nxt = attn_pkg::ph_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= attn_pkg::ph_idle;
            t_lat <= attn_pkg::t_sel_t'(attn_pkg::dim);
        end else begin
            phase <= phase_nxt;
            // T is taken from the first beat only
            if (phase == attn_pkg::ph_idle && in_valid) begin
                t_lat <= t_rows;
            end
        end
    end

endmodule

/* design/attn_index_counter.sv */
`timescale 1ns/1ps

module attn_index_counter (
    input  logic             clk,
    input  logic             rst_n,
    input  attn_pkg::phase_e phase,
    input  attn_pkg::t_sel_t t_lat,
    output attn_pkg::idx_t   row,
    output attn_pkg::idx_t   col,
    output logic             phase_done
);

    logic           counting;
    logic           col_wrap;
    attn_pkg::idx_t t_last;
    attn_pkg::idx_t row_last;
    attn_pkg::idx_t col_last;

    assign t_last = attn_pkg::idx_t'(t_lat - 4'd1);

    // Idle and drain hold the indices at zero
    assign counting = phase inside {attn_pkg::ph_load, attn_pkg::ph_proj_q,
                                    attn_pkg::ph_proj_k, attn_pkg::ph_proj_v,
                                    attn_pkg::ph_score, attn_pkg::ph_emit};

    // Load walks the full 8x8 grid while scores use T x T and other phases T x 8
    assign row_last = (phase == attn_pkg::ph_load) ? attn_pkg::idx_t'(attn_pkg::dim - 1) : t_last;
    assign col_last = (phase == attn_pkg::ph_score) ? t_last : attn_pkg::idx_t'(attn_pkg::dim - 1);

    assign col_wrap   = (col == col_last);
    assign phase_done = counting && col_wrap && (row == row_last);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= '0;
            col <= '0;
        end else if (!counting || phase_done) begin
            row <= '0;
            col <= '0;
        end else if (col_wrap) begin
            col <= '0;
            row <= row + 1'b1;
        end else begin
            col <= col + 1'b1;
        end
    end

endmodule

/* design/attn_operand_store.sv */
`timescale 1ns/1ps

module attn_operand_store (
    input  logic                 clk,
    input  logic                 rst_n,
    input  attn_pkg::phase_e     phase,
    input  attn_pkg::t_sel_t     t_lat,
    input  attn_pkg::idx_t       row,
    input  attn_pkg::idx_t       col,
    input  attn_pkg::load_beat_t beat,
    input  attn_pkg::acc_t       result,
    output attn_pkg::acc_t       lane_a [attn_pkg::dim],
    output attn_pkg::acc_t       lane_b [attn_pkg::dim],
    output logic                 scale_relu,
    output logic                 emit_valid
);

    attn_pkg::elem_t  x_mem  [attn_pkg::dim][attn_pkg::dim];
    attn_pkg::elem_t  wq_mem [attn_pkg::dim][attn_pkg::dim];
    attn_pkg::elem_t  wk_mem [attn_pkg::dim][attn_pkg::dim];
    attn_pkg::elem_t  wv_mem [attn_pkg::dim][attn_pkg::dim];
    attn_pkg::proj_t  q_mem  [attn_pkg::dim][attn_pkg::dim];
    attn_pkg::proj_t  k_mem  [attn_pkg::dim][attn_pkg::dim];
    attn_pkg::proj_t  v_mem  [attn_pkg::dim][attn_pkg::dim];
    attn_pkg::score_t s_mem  [attn_pkg::dim][attn_pkg::dim];

    attn_pkg::load_beat_t beat_q;
    attn_pkg::phase_e     wr_phase;
    attn_pkg::idx_t       wr_row;
    attn_pkg::idx_t       wr_col;
    logic                 row_in_t;

    // Beats land one cycle late so beat k meets load index k
    always_ff @(posedge clk) begin
        beat_q <= beat;
    end

    // Write-back address trails the operands by the dot unit latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_phase <= attn_pkg::ph_idle;
            wr_row   <= '0;
            wr_col   <= '0;
        end else begin
            wr_phase <= phase;
            wr_row   <= row;
            wr_col   <= col;
        end
    end

    assign row_in_t = ({1'b0, row} < t_lat);

    always_ff @(posedge clk) begin
        if (phase == attn_pkg::ph_load) begin
            // X rows past T are kept as zero
            x_mem[row][col]  <= row_in_t ? beat_q.in_data : '0;
            wq_mem[row][col] <= beat_q.w_q;
            wk_mem[row][col] <= beat_q.w_k;
            wv_mem[row][col] <= beat_q.w_v;
        end
        case (wr_phase)
            attn_pkg::ph_proj_q: q_mem[wr_row][wr_col] <= attn_pkg::proj_t'(result);
            attn_pkg::ph_proj_k: k_mem[wr_row][wr_col] <= attn_pkg::proj_t'(result);
            attn_pkg::ph_proj_v: v_mem[wr_row][wr_col] <= attn_pkg::proj_t'(result);
            attn_pkg::ph_score:  s_mem[wr_row][wr_col] <= attn_pkg::score_t'(result);
            default: begin
            end
        endcase
    end

    always_comb begin
        for (int k = 0; k < attn_pkg::dim; k++) begin
            lane_a[k] = '0;
            lane_b[k] = '0;
            case (phase)
                attn_pkg::ph_proj_q: begin
                    lane_a[k] = attn_pkg::acc_t'(x_mem[row][k]);
                    lane_b[k] = attn_pkg::acc_t'(wq_mem[k][col]);
                end
                attn_pkg::ph_proj_k: begin
                    lane_a[k] = attn_pkg::acc_t'(x_mem[row][k]);
                    lane_b[k] = attn_pkg::acc_t'(wk_mem[k][col]);
                end
                attn_pkg::ph_proj_v: begin
                    lane_a[k] = attn_pkg::acc_t'(x_mem[row][k]);
                    lane_b[k] = attn_pkg::acc_t'(wv_mem[k][col]);
                end
                // Q row against K row gives Q times K transposed
                attn_pkg::ph_score: begin
                    lane_a[k] = attn_pkg::acc_t'(q_mem[row][k]);
                    lane_b[k] = attn_pkg::acc_t'(k_mem[col][k]);
                end
                attn_pkg::ph_emit: begin
                    // S columns past T may hold an older run
                    if (k < int'(t_lat)) begin
                        lane_a[k] = attn_pkg::acc_t'(s_mem[row][k]);
                    end
                    lane_b[k] = attn_pkg::acc_t'(v_mem[k][col]);
                end
                default: begin
                end
            endcase
        end
    end

    assign scale_relu = (phase == attn_pkg::ph_score);
    assign emit_valid = (wr_phase == attn_pkg::ph_emit);

endmodule

/* design/attn_dot_unit.sv */
`timescale 1ns/1ps

module attn_dot_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  attn_pkg::acc_t lane_a [attn_pkg::dim],
    input  attn_pkg::acc_t lane_b [attn_pkg::dim],
    input  logic           scale_relu,
    input  logic           emit_valid,
    output attn_pkg::acc_t result,
    output logic           out_valid,
    output attn_pkg::acc_t out_data
);

    localparam int half = attn_pkg::dim / 2;

    attn_pkg::acc_t prod   [attn_pkg::dim];
    attn_pkg::acc_t sum_l1 [half];
    attn_pkg::acc_t sum_l2 [half / 2];
    attn_pkg::acc_t dot;
    attn_pkg::acc_t dot_adj;

    // Eight products feed a three-level adder tree
    always_comb begin
        for (int i = 0; i < attn_pkg::dim; i++) begin
            prod[i] = lane_a[i] * lane_b[i];
        end
        for (int i = 0; i < half; i++) begin
            sum_l1[i] = prod[2 * i] + prod[2 * i + 1];
        end
        for (int i = 0; i < half / 2; i++) begin
            sum_l2[i] = sum_l1[2 * i] + sum_l1[2 * i + 1];
        end
        dot = sum_l2[0] + sum_l2[1];
    end

    // Negative scores clamp to zero and positive ones divide with truncation
    always_comb begin
        dot_adj = dot;
        if (scale_relu) begin
            if (dot < 0) begin
                dot_adj = '0;
            end else begin
                dot_adj = dot / attn_pkg::acc_t'(attn_pkg::score_divisor);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= dot_adj;
        end
    end

    assign out_valid = emit_valid;
    assign out_data  = emit_valid ? result : '0;

endmodule

/* design/attn_top.sv */
`timescale 1ns/1ps

module attn_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  attn_pkg::t_sel_t     t_rows,
    input  attn_pkg::load_beat_t beat,
    output logic                 out_valid,
    output attn_pkg::acc_t       out_data
);

    attn_pkg::phase_e phase;
    attn_pkg::t_sel_t t_lat;
    attn_pkg::idx_t   row;
    attn_pkg::idx_t   col;
    logic             phase_done;
    attn_pkg::acc_t   lane_a [attn_pkg::dim];
    attn_pkg::acc_t   lane_b [attn_pkg::dim];
    attn_pkg::acc_t   result;
    logic             scale_relu;
    logic             emit_valid;

    attn_ctrl_fsm u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .t_rows     (t_rows),
        .phase_done (phase_done),
        .phase      (phase),
        .t_lat      (t_lat)
    );

    attn_index_counter u_index (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .t_lat      (t_lat),
        .row        (row),
        .col        (col),
        .phase_done (phase_done)
    );

    attn_operand_store u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .t_lat      (t_lat),
        .row        (row),
        .col        (col),
        .beat       (beat),
        .result     (result),
        .lane_a     (lane_a),
        .lane_b     (lane_b),
        .scale_relu (scale_relu),
        .emit_valid (emit_valid)
    );

    attn_dot_unit u_dot (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_a     (lane_a),
        .lane_b     (lane_b),
        .scale_relu (scale_relu),
        .emit_valid (emit_valid),
        .result     (result),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

/* sim/attn_properties.sv */
`timescale 1ns/1ps

module attn_properties (
    input logic           clk,
    input logic           rst_n,
    input logic           in_valid,
    input logic           out_valid,
    input attn_pkg::acc_t out_data
);

    // No output words while beats are still loading
    load_quiet: assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> !out_valid)
        else $error("out_valid high while in_valid is high");

    idle_zero: assert property (@(posedge clk) disable iff (!rst_n) !out_valid |-> out_data == '0)
        else $error("out_data nonzero while out_valid is low");

    reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high right after reset");

endmodule

bind attn_top attn_properties props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_data  (out_data)
);

/* sim/attn_checker.sv */
`timescale 1ns/1ps

module attn_checker (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  logic           out_valid,
    input  attn_pkg::acc_t out_data,
    input  logic           arm,
    input  int             exp_count,
    input  attn_pkg::acc_t exp_words [attn_pkg::mat_size],
    output logic           run_done,
    output int             error_count,
    output int             word_count
);

    int   run_idx;
    logic running;

    always @(posedge clk) begin
        if (!rst_n) begin
            run_done    = 1'b0;
            running     = 1'b0;
            run_idx     = 0;
            error_count = 0;
            word_count  = 0;
        end else begin
            if (arm) begin
                running  = 1'b1;
                run_done = 1'b0;
                run_idx  = 0;
            end
            if (out_valid) begin
                if (in_valid) begin
                    $display("Error at %0t ns: an output word appeared during loading", $time);
                    error_count++;
                end
                if (!running || run_idx >= exp_count) begin
                    $display("Error at %0t ns: an output word arrived outside any stream", $time);
                    error_count++;
                end else if (out_data !== exp_words[run_idx]) begin
                    $display("[FAIL] %0t ns: row %0d col %0d expected %0d, got %0d", $time,
                             run_idx / attn_pkg::dim, run_idx % attn_pkg::dim,
                             exp_words[run_idx], out_data);
                    error_count++;
                end
                run_idx++;
                word_count++;
            end else begin
                if (out_data !== '0) begin
                    $display("[FAIL] %0t ns: out_data is %0d while out_valid is low", $time,
                             out_data);
                    error_count++;
                end
                // Stream is over once out_valid drops after its first word
                if (running && run_idx > 0) begin
                    if (run_idx != exp_count) begin
                        $display("[FAIL] %0t ns: stream ended after %0d words, expected %0d",
                                 $time, run_idx, exp_count);
                        error_count++;
                    end
                    running  = 1'b0;
                    run_done = 1'b1;
                end
            end
        end
    end

endmodule

/* sim/attn_tb.sv */
`timescale 1ns/1ps

module attn_tb;

    typedef enum logic [1:0] {fill_random, fill_negative, fill_garbage} fill_e;

    typedef struct packed {
        attn_pkg::t_sel_t t;
        fill_e            mode;
        logic [6:0]       n_words;
    } test_entry_t;

    localparam int n_tests = 5;
    localparam int run_timeout = 1000;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    attn_pkg::t_sel_t     t_rows;
    attn_pkg::load_beat_t beat;
    logic                 out_valid;
    attn_pkg::acc_t       out_data;
    logic                 arm;
    int                   exp_count;
    attn_pkg::acc_t       exp_words [attn_pkg::mat_size];
    logic                 run_done;
    int                   error_count;
    int                   word_count;

    attn_pkg::elem_t x_m  [attn_pkg::dim][attn_pkg::dim];
    attn_pkg::elem_t wq_m [attn_pkg::dim][attn_pkg::dim];
    attn_pkg::elem_t wk_m [attn_pkg::dim][attn_pkg::dim];
    attn_pkg::elem_t wv_m [attn_pkg::dim][attn_pkg::dim];
    test_entry_t     tests [n_tests];
    integer          seed;
    int              tests_run;
    int              failed_tests;
    int              errors_before;
    int              words_before;
    bit              done_ok;
    bit              timed_out;

    attn_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .t_rows    (t_rows),
        .beat      (beat),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    attn_checker check_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .arm         (arm),
        .exp_count   (exp_count),
        .exp_words   (exp_words),
        .run_done    (run_done),
        .error_count (error_count),
        .word_count  (word_count)
    );

    always #2 clk = ~clk;

    function automatic string mode_name(input fill_e mode);
        case (mode)
            fill_negative: return "negative";
            fill_garbage:  return "garbage";
            default:       return "random";
        endcase
    endfunction

    task automatic fill_inputs(input fill_e mode, input int tn);
        for (int r = 0; r < attn_pkg::dim; r++) begin
            for (int c = 0; c < attn_pkg::dim; c++) begin
                x_m[r][c]  = attn_pkg::elem_t'($random(seed));
                wq_m[r][c] = attn_pkg::elem_t'($random(seed));
                wk_m[r][c] = attn_pkg::elem_t'($random(seed));
                wv_m[r][c] = attn_pkg::elem_t'($random(seed));
                // Positive Q against negative K makes every score negative
                if (mode == fill_negative) begin
                    x_m[r][c]  = attn_pkg::elem_t'(1 + ($random(seed) & 7));
                    wq_m[r][c] = attn_pkg::elem_t'(1 + ($random(seed) & 7));
                    wk_m[r][c] = attn_pkg::elem_t'(-1 - ($random(seed) & 7));
                end
                if (mode == fill_garbage && r >= tn) begin
                    x_m[r][c] = x_m[r][c] | 8'sh01;
                end
            end
        end
    endtask

    task automatic build_model(input int tn);
        longint qm [attn_pkg::dim][attn_pkg::dim];
        longint km [attn_pkg::dim][attn_pkg::dim];
        longint vm [attn_pkg::dim][attn_pkg::dim];
        longint sm [attn_pkg::dim][attn_pkg::dim];
        longint xv;
        longint acc;
        for (int i = 0; i < attn_pkg::dim; i++) begin
            for (int j = 0; j < attn_pkg::dim; j++) begin
                qm[i][j] = 0;
                km[i][j] = 0;
                vm[i][j] = 0;
                sm[i][j] = 0;
                exp_words[i * attn_pkg::dim + j] = '0;
                for (int m = 0; m < attn_pkg::dim; m++) begin
                    // X rows at or past T count as zero
                    xv = (i < tn) ? longint'(x_m[i][m]) : 64'sd0;
                    qm[i][j] += xv * longint'(wq_m[m][j]);
                    km[i][j] += xv * longint'(wk_m[m][j]);
                    vm[i][j] += xv * longint'(wv_m[m][j]);
                end
            end
        end
        for (int i = 0; i < tn; i++) begin
            for (int j = 0; j < tn; j++) begin
                acc = 0;
                for (int m = 0; m < attn_pkg::dim; m++) begin
                    acc += qm[i][m] * km[j][m];
                end
                acc = acc / longint'(attn_pkg::score_divisor);
                sm[i][j] = (acc < 0) ? 64'sd0 : acc;
            end
        end
        for (int i = 0; i < tn; i++) begin
            for (int j = 0; j < attn_pkg::dim; j++) begin
                acc = 0;
                for (int m = 0; m < tn; m++) begin
                    acc += sm[i][m] * vm[m][j];
                end
                exp_words[i * attn_pkg::dim + j] = acc;
            end
        end
    endtask

    task automatic load_run(input attn_pkg::t_sel_t t);
        for (int r = 0; r < attn_pkg::dim; r++) begin
            for (int c = 0; c < attn_pkg::dim; c++) begin
                in_valid = 1'b1;
                t_rows   = t;
                beat     = '{x_m[r][c], wq_m[r][c], wk_m[r][c], wv_m[r][c]};
                @(posedge clk);
                #1;
                arm = 1'b0;
            end
        end
        in_valid = 1'b0;
        beat     = '0;
    endtask

    task automatic wait_run_done(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < run_timeout) begin
            @(posedge clk);
            #1;
            cycles++;
            ok = run_done;
        end
    endtask

    initial begin
        seed = 27;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        t_rows = attn_pkg::t_sel_t'(attn_pkg::dim);
        beat = '0;
        arm = 1'b0;
        exp_count = 0;
        tests_run = 0;
        failed_tests = 0;
        timed_out = 1'b0;
        for (int i = 0; i < attn_pkg::mat_size; i++) begin
            exp_words[i] = '0;
        end
        tests[0] = '{4'd8, fill_random, 7'd64};
        tests[1] = '{4'd1, fill_random, 7'd8};
        tests[2] = '{4'd4, fill_garbage, 7'd32};
        tests[3] = '{4'd4, fill_negative, 7'd32};
        tests[4] = '{4'd1, fill_garbage, 7'd8};

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // Each run starts as soon as the previous stream has ended
        for (int n = 0; n < n_tests && !timed_out; n++) begin
            fill_inputs(tests[n].mode, int'(tests[n].t));
            build_model(int'(tests[n].t));
            exp_count = int'(tests[n].n_words);
            errors_before = error_count;
            words_before = word_count;
            arm = 1'b1;
            load_run(tests[n].t);
            wait_run_done(done_ok);
            tests_run++;
            if (!done_ok) begin
                $display("Timeout: test %0d never finished its output stream", n);
                timed_out = 1'b1;
            end else if (error_count == errors_before) begin
                $display("test %0d: T=%0d %s, %0d words, ok", n, tests[n].t,
                         mode_name(tests[n].mode), word_count - words_before);
            end else begin
                $display("test %0d: T=%0d %s, %0d words, %0d errors", n, tests[n].t,
                         mode_name(tests[n].mode), word_count - words_before,
                         error_count - errors_before);
                failed_tests++;
            end
        end

        $display("tests run %0d, failed %0d, words checked %0d, errors %0d",
                 tests_run, failed_tests, word_count, error_count);
        if (!timed_out && failed_tests == 0 && error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* self_attention.f */
design/attn_pkg.sv
design/attn_ctrl_fsm.sv
design/attn_index_counter.sv
design/attn_operand_store.sv
design/attn_dot_unit.sv
design/attn_top.sv
sim/attn_properties.sv
sim/attn_checker.sv
sim/attn_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module attn_tb -f self_attention.f &&
./obj_dir/Vattn_tb | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
